// File: sources.f
rtl/cpu_types_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/control_unit.sv
rtl/fetch_unit.sv
rtl/memory_arbiter.sv
rtl/datapath.sv
rtl/cpu_top.sv
verification/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cpu testbench with verilator, then search the log for the fail message
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module cpu_tb -f sources.f -o cpu_tb_sim \
  && ./obj_dir/cpu_tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "result: FAILED"; exit 1; } \
  || echo "result: PASSED"

// File: verification/cpu_tb.sv
// cpu testbench: wishbone memory model, program table, reference model, checks
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;

  localparam logic [31:0] SEED = 32'h340ab8ea;
  localparam int CYCLES_PER_ROW = 200;
  localparam int QUIET_CYCLES = 20;
  localparam logic [31:0] JAL_PC = 32'h0000_0010;

  // operation codes of the program table
  localparam int T_ADDU  = 0;
  localparam int T_SUBU  = 1;
  localparam int T_AND   = 2;
  localparam int T_OR    = 3;
  localparam int T_SLT   = 4;
  localparam int T_ADDIU = 5;
  localparam int T_ORI   = 6;
  localparam int T_LUI   = 7;
  localparam int T_LDST  = 8;
  localparam int T_BEQ   = 9;
  localparam int T_BNE   = 10;
  localparam int T_J     = 11;
  localparam int T_JAL   = 12;

  logic        CLK;
  logic        nRST;
  logic        wb_cyc, wb_stb, wb_we, wb_ack, halt;
  logic [31:0] wb_adr, wb_dat_o, wb_dat_i;
  logic [3:0]  wb_sel;

  // memory contents and the image loaded while in reset
  logic [31:0] mem   [1024];
  logic [31:0] image [1024];

  // stimulus table columns
  string       names    [$];
  int          ops      [$];
  logic [31:0] a_vals   [$];
  logic [31:0] b_vals   [$];
  logic [31:0] chk_adrs [$];
  logic [31:0] exp_vals [$];

  logic [31:0] stim_rng = SEED;
  logic [31:0] wait_rng = SEED;
  logic [1:0]  wait_left;
  logic        in_req;
  logic        table_ready = 1'b0;
  int          errors = 0;
  int          cur_row = 0;

  cpu_top #(
    .PC_INIT (32'h0000_0000)
  ) uut (
    .CLK      (CLK),
    .nRST     (nRST),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_o (wb_dat_o),
    .wb_sel   (wb_sel),
    .wb_dat_i (wb_dat_i),
    .wb_ack   (wb_ack),
    .halt     (halt)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // ------------------------------------------------------------
  // random source and instruction encoders
  // ------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    stim_rng = xorshift32(stim_rng);
    return stim_rng;
  endfunction

  function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] rd);
    return {6'b000000, rs, rt, rd, 5'b00000, funct};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  // expected stored word, straight from the instruction rules
  function automatic logic [31:0] expected_word(input int op, input logic [31:0] a,
                                                input logic [31:0] b);
    case (op)
      T_ADDU:  return a + b;
      T_SUBU:  return a - b;
      T_AND:   return a & b;
      T_OR:    return a | b;
      T_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      T_ADDIU: return a + {{16{b[15]}}, b[15:0]};
      T_ORI:   return a | {16'h0000, b[15:0]};
      T_LUI:   return {b[15:0], 16'h0000};
      T_LDST:  return a + 32'd1;
      // 1 when the branch skipped the marker, 3 when the marker ran
      T_BEQ:   return (a == b) ? 32'd1 : 32'd3;
      T_BNE:   return (a != b) ? 32'd1 : 32'd3;
      T_J:     return 32'd1;
      T_JAL:   return JAL_PC + 32'd4;
      default: return 32'hxxxx_xxxx;
    endcase
  endfunction

  // ------------------------------------------------------------
  // program table
  // ------------------------------------------------------------
  task automatic add_row(input string name, input int op, input logic [31:0] a,
                         input logic [31:0] b, input bit rand_a, input bit rand_b,
                         input logic [31:0] chk);
    logic [31:0] av;
    logic [31:0] bv;
    av = rand_a ? next_random() : a;
    bv = rand_b ? next_random() : b;
    names.push_back(name);
    ops.push_back(op);
    a_vals.push_back(av);
    b_vals.push_back(bv);
    chk_adrs.push_back(chk);
    exp_vals.push_back(expected_word(op, av, bv));
  endtask

  task automatic build_table();
    add_row("addu",       T_ADDU,  32'h0,         32'h0,         1'b1, 1'b1, 32'h100);
    add_row("subu",       T_SUBU,  32'h0,         32'h0,         1'b1, 1'b1, 32'h100);
    add_row("and",        T_AND,   32'h0,         32'h0,         1'b1, 1'b1, 32'h100);
    add_row("or",         T_OR,    32'h0,         32'h0,         1'b1, 1'b1, 32'h100);
    add_row("slt",        T_SLT,   32'h0,         32'h0,         1'b1, 1'b1, 32'h100);
    add_row("slt_neg",    T_SLT,   32'hffff_fff0, 32'h0000_0005, 1'b0, 1'b0, 32'h100);
    add_row("addiu_neg",  T_ADDIU, 32'h0,         32'h0000_8003, 1'b1, 1'b0, 32'h100);
    add_row("ori_zext",   T_ORI,   32'h0,         32'h0000_f0f0, 1'b1, 1'b0, 32'h100);
    add_row("lui",        T_LUI,   32'h0,         32'h0000_beef, 1'b0, 1'b0, 32'h100);
    add_row("load_store", T_LDST,  32'h0,         32'h0,         1'b1, 1'b0, 32'h100);
    add_row("beq_taken",  T_BEQ,   32'h1234_5678, 32'h1234_5678, 1'b0, 1'b0, 32'h100);
    add_row("beq_not",    T_BEQ,   32'h0000_0001, 32'h0000_0002, 1'b0, 1'b0, 32'h100);
    add_row("bne_taken",  T_BNE,   32'h0000_0005, 32'h0000_0007, 1'b0, 1'b0, 32'h100);
    add_row("bne_not",    T_BNE,   32'h0000_0009, 32'h0000_0009, 1'b0, 1'b0, 32'h100);
    add_row("jump",       T_J,     32'h0,         32'h0,         1'b0, 1'b0, 32'h100);
    add_row("jal_jr",     T_JAL,   32'h0,         32'h0,         1'b0, 1'b0, 32'h100);
  endtask

  // ------------------------------------------------------------
  // program image: r1 = a, r2 = b, operation, store r3, halt
  // ------------------------------------------------------------
  task automatic load_program(input int op, input logic [31:0] a, input logic [31:0] b);
    logic [31:0] marker;
    int          tail;
    // marker sets bit 1 of r3 if it ever runs
    marker = enc_i(cpu_types_pkg::ORI, 5'd3, 5'd3, 16'h0002);
    tail = 5;
    for (int k = 0; k < 1024; k++) begin
      image[k] = {16'hdead, 6'h00, k[9:0]};
    end
    image[0] = enc_i(cpu_types_pkg::LUI, 5'd0, 5'd1, a[31:16]);
    image[1] = enc_i(cpu_types_pkg::ORI, 5'd1, 5'd1, a[15:0]);
    image[2] = enc_i(cpu_types_pkg::LUI, 5'd0, 5'd2, b[31:16]);
    image[3] = enc_i(cpu_types_pkg::ORI, 5'd2, 5'd2, b[15:0]);
    case (op)
      T_ADDU:  image[4] = enc_r(cpu_types_pkg::ADDU, 5'd1, 5'd2, 5'd3);
      T_SUBU:  image[4] = enc_r(cpu_types_pkg::SUBU, 5'd1, 5'd2, 5'd3);
      T_AND:   image[4] = enc_r(cpu_types_pkg::AND, 5'd1, 5'd2, 5'd3);
      T_OR:    image[4] = enc_r(cpu_types_pkg::OR, 5'd1, 5'd2, 5'd3);
      T_SLT:   image[4] = enc_r(cpu_types_pkg::SLT, 5'd1, 5'd2, 5'd3);
      T_ADDIU: image[4] = enc_i(cpu_types_pkg::ADDIU, 5'd1, 5'd3, b[15:0]);
      T_ORI:   image[4] = enc_i(cpu_types_pkg::ORI, 5'd1, 5'd3, b[15:0]);
      T_LUI:   image[4] = enc_i(cpu_types_pkg::LUI, 5'd0, 5'd3, b[15:0]);
      T_LDST: begin
        // store a, load it into r4, add one
        image[4] = enc_i(cpu_types_pkg::SW, 5'd0, 5'd1, 16'h0200);
        image[5] = enc_i(cpu_types_pkg::LW, 5'd0, 5'd4, 16'h0200);
        image[6] = enc_i(cpu_types_pkg::ADDIU, 5'd4, 5'd3, 16'h0001);
        tail = 7;
      end
      T_BEQ, T_BNE: begin
        // offset 1 skips the marker at index 6
        image[4] = enc_i(cpu_types_pkg::ORI, 5'd0, 5'd3, 16'h0001);
        image[5] = enc_i((op == T_BEQ) ? cpu_types_pkg::BEQ : cpu_types_pkg::BNE,
                         5'd1, 5'd2, 16'h0001);
        image[6] = marker;
        tail = 7;
      end
      T_J: begin
        image[4] = enc_i(cpu_types_pkg::ORI, 5'd0, 5'd3, 16'h0001);
        image[5] = enc_j(cpu_types_pkg::J, 26'd7);
        image[6] = marker;
        tail = 7;
      end
      T_JAL: begin
        // subroutine at index 7 only returns
        image[4] = enc_j(cpu_types_pkg::JAL, 26'd7);
        image[5] = enc_i(cpu_types_pkg::SW, 5'd0, 5'd31, 16'h0100);
        image[6] = enc_i(cpu_types_pkg::HALT, 5'd0, 5'd0, 16'h0000);
        image[7] = enc_r(cpu_types_pkg::JR, 5'd31, 5'd0, 5'd0);
        tail = 0;
      end
      default: tail = 5;
    endcase
    if (tail != 0) begin
      image[tail]     = enc_i(cpu_types_pkg::SW, 5'd0, 5'd3, 16'h0100);
      image[tail + 1] = enc_i(cpu_types_pkg::HALT, 5'd0, 5'd0, 16'h0000);
    end
  endtask

  // ------------------------------------------------------------
  // wishbone memory model, 0 to 3 wait states per cycle
  // ------------------------------------------------------------
  always @(negedge CLK) begin
    if (!nRST) begin
      for (int j = 0; j < 1024; j++) begin
        mem[j] = image[j];
      end
      wb_ack <= 1'b0;
      in_req = 1'b0;
    end else if (wb_ack) begin
      // one ack per cycle, then idle
      wb_ack <= 1'b0;
      in_req = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      // word access only, all byte lanes
      assert (wb_sel == 4'hf) else begin
        $display("Mismatch %s wb_sel: expected %h actual %h", names[cur_row], 4'hf, wb_sel);
        errors++;
      end
      if (!in_req) begin
        in_req = 1'b1;
        wait_rng = xorshift32(wait_rng);
        wait_left = wait_rng[1:0];
      end
      if (wait_left == 2'd0) begin
        wb_ack <= 1'b1;
        if (wb_we) begin
          mem[wb_adr[11:2]] = wb_dat_o;
        end else begin
          wb_dat_i <= mem[wb_adr[11:2]];
        end
      end else begin
        wait_left = wait_left - 2'd1;
      end
    end
  end

  // ------------------------------------------------------------
  // one table row: reset, run to halt, watch the bus, check memory
  // ------------------------------------------------------------
  task automatic run_row(input int i);
    logic [31:0] got;
    @(negedge CLK);
    nRST = 1'b0;
    load_program(ops[i], a_vals[i], b_vals[i]);
    repeat (2) @(negedge CLK);
    nRST = 1'b1;
    while (!halt) begin
      @(negedge CLK);
    end
    // halted core must stay off the bus
    for (int q = 0; q < QUIET_CYCLES; q++) begin
      @(negedge CLK);
      assert (!wb_cyc) else begin
        $display("%s: bus cycle started after halt", names[i]);
        errors++;
      end
      assert (halt) else begin
        $display("%s: halt dropped before the next reset", names[i]);
        errors++;
      end
    end
    got = mem[chk_adrs[i][11:2]];
    assert (got == exp_vals[i]) else begin
      $display("Mismatch %s: expected %h actual %h", names[i], exp_vals[i], got);
      errors++;
    end
  endtask

  initial begin
    nRST = 1'b0;
    wb_ack = 1'b0;
    wb_dat_i = 32'h0;
    in_req = 1'b0;
    wait_left = 2'd0;
    build_table();
    table_ready = 1'b1;
    for (int i = 0; i < names.size(); i++) begin
      cur_row = i;
      run_row(i);
    end
    $display("tests run %0d, errors %0d", names.size(), errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog, a fixed cycle budget per row
  initial begin
    wait (table_ready);
    repeat (names.size() * CYCLES_PER_ROW) @(posedge CLK);
    $display("timeout: the program table did not finish within %0d cycles",
             names.size() * CYCLES_PER_ROW);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/cpu_top.sv
// cpu top: fetch unit, datapath and arbiter onto one wishbone master port
`timescale 1ns/10ps
`default_nettype none

module cpu_top #(
  parameter logic [cpu_types_pkg::WORD_W-1:0] PC_INIT = '0
) (
  input  logic                             CLK,
  input  logic                             nRST,
  output logic                             wb_cyc,
  output logic                             wb_stb,
  output logic                             wb_we,
  output logic [cpu_types_pkg::WORD_W-1:0] wb_adr,
  output logic [cpu_types_pkg::WORD_W-1:0] wb_dat_o,
  output logic [3:0]                       wb_sel,
  input  logic [cpu_types_pkg::WORD_W-1:0] wb_dat_i,
  input  logic                             wb_ack,
  output logic                             halt
);

  // fetch side bus
  logic f_cyc, f_stb, f_ack;
  logic [cpu_types_pkg::WORD_W-1:0] f_adr, f_dat_i;
  // data side bus
  logic d_cyc, d_stb, d_we, d_ack;
  logic [cpu_types_pkg::WORD_W-1:0] d_adr, d_dat_o, d_dat_i;
  // fetch to datapath
  logic instr_valid, instr_take, redirect;
  logic [cpu_types_pkg::WORD_W-1:0] instr, instr_pc, redirect_pc;

  fetch_unit #(
    .PC_INIT (PC_INIT)
  ) u_fetch (
    .CLK         (CLK),
    .nRST        (nRST),
    .f_cyc       (f_cyc),
    .f_stb       (f_stb),
    .f_adr       (f_adr),
    .f_dat_i     (f_dat_i),
    .f_ack       (f_ack),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_pc    (instr_pc),
    .instr_take  (instr_take),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halt        (halt)
  );

  datapath u_dp (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_pc    (instr_pc),
    .instr_take  (instr_take),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .d_cyc       (d_cyc),
    .d_stb       (d_stb),
    .d_we        (d_we),
    .d_adr       (d_adr),
    .d_dat_o     (d_dat_o),
    .d_dat_i     (d_dat_i),
    .d_ack       (d_ack),
    .halt        (halt)
  );

  memory_arbiter u_arb (
    .CLK      (CLK),
    .nRST     (nRST),
    .f_cyc    (f_cyc),
    .f_stb    (f_stb),
    .f_adr    (f_adr),
    .f_dat_i  (f_dat_i),
    .f_ack    (f_ack),
    .d_cyc    (d_cyc),
    .d_stb    (d_stb),
    .d_we     (d_we),
    .d_adr    (d_adr),
    .d_dat_o  (d_dat_o),
    .d_dat_i  (d_dat_i),
    .d_ack    (d_ack),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_o (wb_dat_o),
    .wb_sel   (wb_sel),
    .wb_dat_i (wb_dat_i),
    .wb_ack   (wb_ack)
  );

endmodule

`default_nettype wire

// File: rtl/datapath.sv
// datapath: decode, register file, alu, next pc, data wishbone master, halt flag
`timescale 1ns/10ps
`default_nettype none

module datapath (
  input  logic                             CLK,
  input  logic                             nRST,
  input  logic                             instr_valid,
  input  cpu_types_pkg::instr_u            instr,
  input  logic [cpu_types_pkg::WORD_W-1:0] instr_pc,
  output logic                             instr_take,
  output logic                             redirect,
  output logic [cpu_types_pkg::WORD_W-1:0] redirect_pc,
  output logic                             d_cyc,
  output logic                             d_stb,
  output logic                             d_we,
  output logic [cpu_types_pkg::WORD_W-1:0] d_adr,
  output logic [cpu_types_pkg::WORD_W-1:0] d_dat_o,
  input  logic [cpu_types_pkg::WORD_W-1:0] d_dat_i,
  input  logic                             d_ack,
  output logic                             halt
);

  cpu_types_pkg::aluop_t alu_op;
  logic alu_src, ext_signed, reg_dst, reg_wr, mem_rd, mem_wr;
  logic beq_s, bne_s, jump_s, jal_s, jr_s, halt_s;
  logic [cpu_types_pkg::WORD_W-1:0] rdat1, rdat2, wdat, imm_ext, alu_b, alu_out, pc_plus4;
  logic [4:0] wsel;
  logic wen, zero, active, mem_op, br_taken;

  control_unit u_cu (
    .instr      (instr),
    .alu_op     (alu_op),
    .alu_src    (alu_src),
    .ext_signed (ext_signed),
    .reg_dst    (reg_dst),
    .reg_wr     (reg_wr),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .beq_s      (beq_s),
    .bne_s      (bne_s),
    .jump_s     (jump_s),
    .jal_s      (jal_s),
    .jr_s       (jr_s),
    .halt_s     (halt_s)
  );

  register_file u_rf (
    .CLK   (CLK),
    .nRST  (nRST),
    .rsel1 (instr.r_view.rs),
    .rsel2 (instr.r_view.rt),
    .wsel  (wsel),
    .wen   (wen),
    .wdat  (wdat),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  alu u_alu (
    .a      (rdat1),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_out),
    .zero   (zero)
  );

  // ------------------------------------------------------------
  // operand select
  // ------------------------------------------------------------
  assign imm_ext = ext_signed ? {{16{instr.i_view.imm[15]}}, instr.i_view.imm}
                              : {16'h0000, instr.i_view.imm};
  assign alu_b    = alu_src ? imm_ext : rdat2;
  assign pc_plus4 = instr_pc + 32'd4;

  // ------------------------------------------------------------
  // execute and memory handshake
  // ------------------------------------------------------------
  // halt instruction is never taken, so the buffer stays full
  assign active = instr_valid & ~halt & ~halt_s;
  assign mem_op = mem_rd | mem_wr;
  assign d_cyc   = active & mem_op;
  assign d_stb   = d_cyc;
  assign d_we    = d_cyc & mem_wr;
  assign d_adr   = alu_out;
  assign d_dat_o = rdat2;
  // loads and stores wait for ack
  assign instr_take = active & (~mem_op | d_ack);

  // next pc
  assign br_taken = (beq_s & zero) | (bne_s & ~zero);
  assign redirect = instr_take & (br_taken | jump_s | jr_s);

  always_comb begin
    if (jr_s) begin
      redirect_pc = rdat1;
    end else if (jump_s) begin
      redirect_pc = {pc_plus4[31:28], instr.i_view[25:0], 2'b00};
    end else begin
      redirect_pc = pc_plus4 + {imm_ext[29:0], 2'b00};
    end
  end

  // write-back, jal links into r31
  assign wen  = instr_take & reg_wr;
  assign wsel = jal_s ? 5'd31 : (reg_dst ? instr.r_view.rd : instr.r_view.rt);
  assign wdat = mem_rd ? d_dat_i : (jal_s ? pc_plus4 : alu_out);

  // sticky halt
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (instr_valid && halt_s) begin
      halt <= 1'b1;
    end
  end

  // once halted, stays halted and quiet
  a_halt_quiet: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> (halt && !instr_take && !d_cyc));

endmodule

`default_nettype wire

// File: rtl/memory_arbiter.sv
// memory arbiter: fetch and data masters onto one wishbone port, data first
`timescale 1ns/10ps
`default_nettype none

module memory_arbiter (
  input  logic                             CLK,
  input  logic                             nRST,
  input  logic                             f_cyc,
  input  logic                             f_stb,
  input  logic [cpu_types_pkg::WORD_W-1:0] f_adr,
  output logic [cpu_types_pkg::WORD_W-1:0] f_dat_i,
  output logic                             f_ack,
  input  logic                             d_cyc,
  input  logic                             d_stb,
  input  logic                             d_we,
  input  logic [cpu_types_pkg::WORD_W-1:0] d_adr,
  input  logic [cpu_types_pkg::WORD_W-1:0] d_dat_o,
  output logic [cpu_types_pkg::WORD_W-1:0] d_dat_i,
  output logic                             d_ack,
  output logic                             wb_cyc,
  output logic                             wb_stb,
  output logic                             wb_we,
  output logic [cpu_types_pkg::WORD_W-1:0] wb_adr,
  output logic [cpu_types_pkg::WORD_W-1:0] wb_dat_o,
  output logic [3:0]                       wb_sel,
  input  logic [cpu_types_pkg::WORD_W-1:0] wb_dat_i,
  input  logic                             wb_ack
);

  localparam logic [1:0] GNT_IDLE  = 2'd0;
  localparam logic [1:0] GNT_FETCH = 2'd1;
  localparam logic [1:0] GNT_DATA  = 2'd2;

  logic [1:0] gnt;
  logic       sel_f, sel_d;

  // ------------------------------------------------------------
  // grant state, only changes hands through idle
  // ------------------------------------------------------------
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      gnt <= GNT_IDLE;
    end else begin
      case (gnt)
        GNT_IDLE: begin
          if (d_cyc) begin
            gnt <= GNT_DATA;
          end else if (f_cyc) begin
            gnt <= GNT_FETCH;
          end
        end
        GNT_FETCH: begin
          if (!f_cyc) begin
            gnt <= GNT_IDLE;
          end
        end
        GNT_DATA: begin
          if (!d_cyc) begin
            gnt <= GNT_IDLE;
          end
        end
        default: begin
          gnt <= GNT_IDLE;
        end
      endcase
    end
  end

  assign sel_f = (gnt == GNT_FETCH);
  assign sel_d = (gnt == GNT_DATA);

  // bus muxing, fetch never writes
  assign wb_cyc   = (sel_f & f_cyc) | (sel_d & d_cyc);
  assign wb_stb   = (sel_f & f_stb) | (sel_d & d_stb);
  assign wb_we    = sel_d & d_we;
  assign wb_adr   = sel_d ? d_adr : f_adr;
  assign wb_dat_o = d_dat_o;
  assign wb_sel   = 4'hf;

  // acks steered to the granted master only
  assign f_ack   = sel_f & wb_ack;
  assign d_ack   = sel_d & wb_ack;
  assign f_dat_i = wb_dat_i;
  assign d_dat_i = wb_dat_i;

  // every slave ack lands on exactly one master
  a_ack_one: assert property (@(posedge CLK) disable iff (!nRST)
    wb_ack |-> (f_ack != d_ack));

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
// fetch unit: pc, wishbone fetch master, one-entry prefetch buffer, redirect flush
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
  parameter logic [cpu_types_pkg::WORD_W-1:0] PC_INIT = '0
) (
  input  logic                             CLK,
  input  logic                             nRST,
  output logic                             f_cyc,
  output logic                             f_stb,
  output logic [cpu_types_pkg::WORD_W-1:0] f_adr,
  input  logic [cpu_types_pkg::WORD_W-1:0] f_dat_i,
  input  logic                             f_ack,
  output logic                             instr_valid,
  output logic [cpu_types_pkg::WORD_W-1:0] instr,
  output logic [cpu_types_pkg::WORD_W-1:0] instr_pc,
  input  logic                             instr_take,
  input  logic                             redirect,
  input  logic [cpu_types_pkg::WORD_W-1:0] redirect_pc,
  input  logic                             halt
);

  logic [cpu_types_pkg::WORD_W-1:0] pc, req_adr, buf_instr, buf_pc;
  logic busy, squash, buf_valid, can_start, fill;

  // new fetch when the buffer is empty or being emptied
  assign can_start = (~buf_valid | instr_take) & ~redirect & ~halt;
  // busy keeps the request up until ack
  assign f_cyc = busy | can_start;
  assign f_stb = f_cyc;
  assign f_adr = busy ? req_adr : pc;
  // squashed or redirected data never enters the buffer
  assign fill = f_ack & ~squash & ~redirect;

  // ------------------------------------------------------------
  // control state
  // ------------------------------------------------------------
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc        <= PC_INIT;
      busy      <= 1'b0;
      squash    <= 1'b0;
      buf_valid <= 1'b0;
    end else begin
      busy <= f_cyc & ~f_ack;
      // redirect wins over everything
      if (redirect) begin
        pc <= redirect_pc;
      end else if (fill) begin
        pc <= pc + 32'd4;
      end
      // drop the data of a fetch still in flight
      if (f_ack) begin
        squash <= 1'b0;
      end else if (redirect && busy) begin
        squash <= 1'b1;
      end
      if (redirect) begin
        buf_valid <= 1'b0;
      end else if (fill) begin
        buf_valid <= 1'b1;
      end else if (instr_take) begin
        buf_valid <= 1'b0;
      end
    end
  end

  // address and buffer payload
  always_ff @(posedge CLK) begin
    req_adr <= f_adr;
    if (fill) begin
      buf_instr <= f_dat_i;
      buf_pc    <= f_adr;
    end
  end

  assign instr_valid = buf_valid;
  assign instr       = buf_instr;
  assign instr_pc    = buf_pc;

  // classic cycle holds strobe and address until ack
  a_req_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (f_cyc && !f_ack) |=> (f_stb && f_cyc && $stable(f_adr)));

endmodule

`default_nettype wire

// File: rtl/control_unit.sv
// control unit: instruction word to alu op and datapath strobes
`timescale 1ns/10ps
`default_nettype none

module control_unit (
  input  cpu_types_pkg::instr_u instr,
  output cpu_types_pkg::aluop_t alu_op,
  output logic                  alu_src,
  output logic                  ext_signed,
  output logic                  reg_dst,
  output logic                  reg_wr,
  output logic                  mem_rd,
  output logic                  mem_wr,
  output logic                  beq_s,
  output logic                  bne_s,
  output logic                  jump_s,
  output logic                  jal_s,
  output logic                  jr_s,
  output logic                  halt_s
);

  always_comb begin
    // defaults decode to a no-op
    alu_op     = cpu_types_pkg::ALU_ADD;
    alu_src    = 1'b0;
    ext_signed = 1'b0;
    reg_dst    = 1'b0;
    reg_wr     = 1'b0;
    mem_rd     = 1'b0;
    mem_wr     = 1'b0;
    beq_s      = 1'b0;
    bne_s      = 1'b0;
    jump_s     = 1'b0;
    jal_s      = 1'b0;
    jr_s       = 1'b0;
    halt_s     = 1'b0;
    case (instr.i_view.opcode)
      cpu_types_pkg::RTYPE: begin
        // r-type writes rd
        reg_dst = 1'b1;
        case (instr.r_view.funct)
          cpu_types_pkg::ADDU: begin
            reg_wr = 1'b1;
          end
          cpu_types_pkg::SUBU: begin
            reg_wr = 1'b1;
            alu_op = cpu_types_pkg::ALU_SUB;
          end
          cpu_types_pkg::AND: begin
            reg_wr = 1'b1;
            alu_op = cpu_types_pkg::ALU_AND;
          end
          cpu_types_pkg::OR: begin
            reg_wr = 1'b1;
            alu_op = cpu_types_pkg::ALU_OR;
          end
          cpu_types_pkg::SLT: begin
            reg_wr = 1'b1;
            alu_op = cpu_types_pkg::ALU_SLT;
          end
          cpu_types_pkg::JR: begin
            jr_s = 1'b1;
          end
          default: begin
            reg_dst = 1'b0;
          end
        endcase
      end
      cpu_types_pkg::ADDIU: begin
        alu_src    = 1'b1;
        ext_signed = 1'b1;
        reg_wr     = 1'b1;
      end
      cpu_types_pkg::ORI: begin
        // zero extended
        alu_src = 1'b1;
        reg_wr  = 1'b1;
        alu_op  = cpu_types_pkg::ALU_OR;
      end
      cpu_types_pkg::LUI: begin
        alu_src = 1'b1;
        reg_wr  = 1'b1;
        alu_op  = cpu_types_pkg::ALU_LUI;
      end
      cpu_types_pkg::LW: begin
        alu_src    = 1'b1;
        ext_signed = 1'b1;
        reg_wr     = 1'b1;
        mem_rd     = 1'b1;
      end
      cpu_types_pkg::SW: begin
        alu_src    = 1'b1;
        ext_signed = 1'b1;
        mem_wr     = 1'b1;
      end
      cpu_types_pkg::BEQ: begin
        // compare by subtract, offset sign extended
        ext_signed = 1'b1;
        beq_s      = 1'b1;
        alu_op     = cpu_types_pkg::ALU_SUB;
      end
      cpu_types_pkg::BNE: begin
        ext_signed = 1'b1;
        bne_s      = 1'b1;
        alu_op     = cpu_types_pkg::ALU_SUB;
      end
      cpu_types_pkg::J: begin
        jump_s = 1'b1;
      end
      cpu_types_pkg::JAL: begin
        // link into r31
        jump_s = 1'b1;
        jal_s  = 1'b1;
        reg_wr = 1'b1;
      end
      cpu_types_pkg::HALT: begin
        halt_s = 1'b1;
      end
      default: begin
        halt_s = 1'b0;
      end
    endcase
  end

  // a memory access is either a load or a store
  a_mem_excl: assert property (@(instr) !(mem_rd && mem_wr));

endmodule

`default_nettype wire

// File: rtl/register_file.sv
// register file: 32 x 32, two async read ports, one write port, r0 reads zero
`timescale 1ns/10ps
`default_nettype none

module register_file (
  input  logic                             CLK,
  input  logic                             nRST,
  input  logic [4:0]                       rsel1,
  input  logic [4:0]                       rsel2,
  input  logic [4:0]                       wsel,
  input  logic                             wen,
  input  logic [cpu_types_pkg::WORD_W-1:0] wdat,
  output logic [cpu_types_pkg::WORD_W-1:0] rdat1,
  output logic [cpu_types_pkg::WORD_W-1:0] rdat2
);

  logic [cpu_types_pkg::WORD_W-1:0] regs [32];

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wsel != 5'd0)) begin
      regs[wsel] <= wdat;
    end
  end

  // r0 hardwired to zero
  assign rdat1 = (rsel1 == 5'd0) ? '0 : regs[rsel1];
  assign rdat2 = (rsel2 == 5'd0) ? '0 : regs[rsel2];

endmodule

`default_nettype wire

// File: rtl/alu.sv
// alu: add, sub, and, or, set-less-than, load-upper, zero flag
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  logic [cpu_types_pkg::WORD_W-1:0] a,
  input  logic [cpu_types_pkg::WORD_W-1:0] b,
  input  cpu_types_pkg::aluop_t            op,
  output logic [cpu_types_pkg::WORD_W-1:0] result,
  output logic                             zero
);

  always_comb begin
    case (op)
      cpu_types_pkg::ALU_ADD: begin
        result = a + b;
      end
      cpu_types_pkg::ALU_SUB: begin
        result = a - b;
      end
      cpu_types_pkg::ALU_AND: begin
        result = a & b;
      end
      cpu_types_pkg::ALU_OR: begin
        result = a | b;
      end
      cpu_types_pkg::ALU_SLT: begin
        // signed compare, result is 0 or 1
        result = {{(cpu_types_pkg::WORD_W-1){1'b0}}, ($signed(a) < $signed(b))};
      end
      cpu_types_pkg::ALU_LUI: begin
        // immediate into the upper half
        result = {b[15:0], 16'h0000};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // beq and bne look at this after a subtract
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: rtl/cpu_types_pkg.sv
// opcode and function enums, alu operations, instruction word views, word width
`default_nettype none

package cpu_types_pkg;

  // datapath word width
  localparam int WORD_W = 32;

  // ------------------------------------------------------------
  // primary opcodes, halt is all ones
  // ------------------------------------------------------------
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDIU = 6'b001001,
    ORI   = 6'b001101,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  // function field under RTYPE
  typedef enum logic [5:0] {
    JR   = 6'b001000,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    SLT  = 6'b101010
  } funct_t;

  // alu operation select
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_LUI
  } aluop_t;

  // ------------------------------------------------------------
  // one instruction word, two field layouts
  // i_view low 26 bits double as the jump target
  // ------------------------------------------------------------
  typedef union packed {
    struct packed {
      opcode_t     opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      logic [4:0]  shamt;
      funct_t      funct;
    } r_view;
    struct packed {
      opcode_t     opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } i_view;
  } instr_u;

endpackage

`default_nettype wire
